/* Makefile */
TB_TOP = tb_vid_framebuf

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing --assert -sv -f vid_framebuf.f --top-module $(TB_TOP) -Mdir obj_dir
	@out=$$(./obj_dir/V$(TB_TOP)); echo "$$out"; echo "$$out" | grep -q "TEST PASS"

lint:
	verilator --lint-only --timing -sv -f vid_framebuf.f --top-module vid_framebuf

clean:
	rm -rf obj_dir

/* logic/fb_pkg.sv */
// Shared widths and types for the frame buffer reader
// Single clock; depths are powers of two
package fb_pkg;

	//////////////////////////////
	// Widths and depths
	//////////////////////////////

	// Bus side
	localparam int ADDR_W       = 20;
	localparam int DATA_W       = 32;

	// Pixel side, packed MSB first into each bus word
	localparam int PIX_W        = 8;
	localparam int PIX_PER_WORD = 4;

	// Row and column counters
	localparam int DIM_W        = 11;

	// FIFO and burst sizing
	localparam int FIFO_LG      = 5;
	localparam int BURST_LG     = 4;
	localparam int FIFO_DEPTH   = 1 << FIFO_LG;
	localparam int BURST_LEN    = 1 << BURST_LG;

	//////////////////////////////
	// Types
	//////////////////////////////

	typedef logic [ADDR_W-1:0]  addr_t;
	typedef logic [DATA_W-1:0]  word_t;
	typedef logic [PIX_W-1:0]   pix_t;
	typedef logic [DIM_W-1:0]   dim_t;
	typedef logic [FIFO_LG:0]   fill_t;

	// Frame geometry, stable while enabled
	typedef struct packed {
		addr_t base;
		dim_t  mem_words;
		dim_t  height;
	} vid_cfg_t;

	// Bus word tagged with its frame position
	typedef struct packed {
		logic  vlast;
		logic  hlast;
		word_t data;
	} px_word_t;

	// One AXI stream beat
	typedef struct packed {
		pix_t data;
		logic last;
		logic user;
	} vid_beat_t;

	// Reader FSM
	typedef enum logic [1:0] {
		RD_IDLE,
		RD_REQ,
		RD_DRAIN
	} rd_state_t;

endpackage

/* logic/px_fifo.sv */
// Synchronous FIFO, combinational head; writer must respect o_fill
`timescale 1ns/1ps
module px_fifo import fb_pkg::*; (
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_wr,
	input  px_word_t i_wr_word,
	input  logic     i_rd,
	output px_word_t o_rd_word,
	output logic     o_empty,
	output fill_t    o_fill
);

	px_word_t mem [FIFO_DEPTH];

	// Extra MSB tells full from empty
	fill_t    wr_ptr;
	fill_t    rd_ptr;

	//////////////////////////////
	// Pointers
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end
		else
		begin
			if (i_wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (i_rd)
				rd_ptr <= rd_ptr + 1'b1;
		end
	end

	// Storage
	always_ff @(posedge i_clk)
	begin
		if (i_wr)
			mem[wr_ptr[FIFO_LG-1:0]] <= i_wr_word;
	end

	assign o_fill    = wr_ptr - rd_ptr;
	assign o_empty   = (wr_ptr == rd_ptr);
	assign o_rd_word = mem[rd_ptr[FIFO_LG-1:0]];

	// Reader sizes its bursts from o_fill, unpacker checks o_empty
	a_no_ovf: assert property (@(posedge i_clk) disable iff (i_reset)
		i_wr |-> (o_fill != fill_t'(FIFO_DEPTH)));
	a_no_unf: assert property (@(posedge i_clk) disable iff (i_reset)
		i_rd |-> !o_empty);

endmodule

/* logic/px_unpacker.sv */
// Splits tagged words into pixels, MSB first
// TLAST marks row ends, TUSER the first pixel of a frame
`timescale 1ns/1ps
module px_unpacker import fb_pkg::*; (
	input  logic      i_clk,
	input  logic      i_reset,
	input  px_word_t  i_word,
	input  logic      i_empty,
	output logic      o_pop,
	input  logic      i_vid_ready,
	output logic      o_vid_valid,
	output vid_beat_t o_vid_beat
);

	localparam int IDX_W = $clog2(PIX_PER_WORD);
	typedef logic [IDX_W-1:0] idx_t;

	word_t sreg;
	idx_t  px_idx;
	logic  hlast;
	logic  vlast;
	logic  sof;
	logic  xfer;
	logic  last_px;

	assign xfer    = o_vid_valid && i_vid_ready;
	assign last_px = (px_idx == idx_t'(PIX_PER_WORD - 1));

	// Refill when idle or as the last pixel leaves, so no bubble
	assign o_pop   = !i_empty && (!o_vid_valid || (xfer && last_px));

	//////////////////////////////
	// Control
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			o_vid_valid <= 1'b0;
			px_idx      <= '0;
			hlast       <= 1'b0;
			vlast       <= 1'b0;
			sof         <= 1'b1;
		end
		else
		begin
			if (o_pop)
			begin
				o_vid_valid <= 1'b1;
				px_idx      <= '0;
				hlast       <= i_word.hlast;
				vlast       <= i_word.vlast;
			end
			else if (xfer)
			begin
				px_idx <= px_idx + 1'b1;
				// Word used up and nothing waiting
				if (last_px)
					o_vid_valid <= 1'b0;
			end

			// Next frame starts after the bottom right pixel
			if (xfer)
				sof <= last_px && hlast && vlast;
		end
	end

	//////////////////////////////
	// Pixel shifter
	//////////////////////////////

	always_ff @(posedge i_clk)
	begin
		if (o_pop)
			sreg <= i_word.data;
		else if (xfer)
			sreg <= {sreg[DATA_W-PIX_W-1:0], pix_t'(0)};
	end

	always_comb
	begin
		o_vid_beat.data = sreg[DATA_W-1 -: PIX_W];
		o_vid_beat.last = hlast && last_px;
		o_vid_beat.user = sof;
	end

	// Stream rule, held beat must not change
	a_hold: assert property (@(posedge i_clk) disable iff (i_reset)
		(o_vid_valid && !i_vid_ready) |=> (o_vid_valid && $stable(o_vid_beat)));

endmodule

/* logic/vid_framebuf.sv */
// Frame buffer reader top, one clock
// Disable only between runs; the FIFO is not flushed
`timescale 1ns/1ps
module vid_framebuf import fb_pkg::*; (
	input  logic      i_clk,
	input  logic      i_reset,
	input  logic      i_cfg_en,
	input  vid_cfg_t  i_cfg,
	output logic      o_wb_cyc,
	output logic      o_wb_stb,
	output addr_t     o_wb_addr,
	input  logic      i_wb_stall,
	input  logic      i_wb_ack,
	input  word_t     i_wb_data,
	output logic      o_vid_valid,
	output vid_beat_t o_vid_beat,
	input  logic      i_vid_ready
);

	// Reader to FIFO
	logic     push;
	px_word_t push_word;
	fill_t    fill;

	// FIFO to unpacker
	logic     pop;
	logic     empty;
	px_word_t head_word;

	// Bus master and position tagging
	wb_burst_reader wb_burst_reader_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cfg_en    (i_cfg_en),
		.i_cfg       (i_cfg),
		.i_fill      (fill),
		.o_wb_cyc    (o_wb_cyc),
		.o_wb_stb    (o_wb_stb),
		.o_wb_addr   (o_wb_addr),
		.i_wb_stall  (i_wb_stall),
		.i_wb_ack    (i_wb_ack),
		.i_wb_data   (i_wb_data),
		.o_push      (push),
		.o_push_word (push_word)
	);

	px_fifo px_fifo_i (
		.i_clk     (i_clk),
		.i_reset   (i_reset),
		.i_wr      (push),
		.i_wr_word (push_word),
		.i_rd      (pop),
		.o_rd_word (head_word),
		.o_empty   (empty),
		.o_fill    (fill)
	);

	// Pixel stream out
	px_unpacker px_unpacker_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_word      (head_word),
		.i_empty     (empty),
		.o_pop       (pop),
		.i_vid_ready (i_vid_ready),
		.o_vid_valid (o_vid_valid),
		.o_vid_beat  (o_vid_beat)
	);

endmodule

/* logic/wb_burst_reader.sv */
// Pipelined read-only Wishbone master; needs mem_words >= 2 and height >= 2
// Config must hold still while i_cfg_en is high
`timescale 1ns/1ps
module wb_burst_reader import fb_pkg::*; (
	input  logic     i_clk,
	input  logic     i_reset,
	input  logic     i_cfg_en,
	input  vid_cfg_t i_cfg,
	input  fill_t    i_fill,
	output logic     o_wb_cyc,
	output logic     o_wb_stb,
	output addr_t    o_wb_addr,
	input  logic     i_wb_stall,
	input  logic     i_wb_ack,
	input  word_t    i_wb_data,
	output logic     o_push,
	output px_word_t o_push_word
);

	typedef logic [BURST_LG:0]  cnt_t;
	typedef logic [FIFO_LG+1:0] sum_t;

	rd_state_t state;
	cnt_t      outstanding;
	cnt_t      req_cnt;
	sum_t      committed;
	logic      accept;
	logic      last_req;

	// Request side position
	dim_t      req_col;
	dim_t      req_row;
	addr_t     row_addr;

	// Ack side position
	dim_t      ack_col;
	dim_t      ack_row;
	logic      ack_hlast;

	assign accept    = o_wb_stb && !i_wb_stall;
	assign o_push    = o_wb_cyc && i_wb_ack;

	// Words owed to the FIFO once this request lands
	assign committed = sum_t'(outstanding) + sum_t'(i_fill) + 1'b1;
	assign last_req  = (req_cnt == cnt_t'(BURST_LEN - 1))
		|| (committed >= sum_t'(FIFO_DEPTH));

	//////////////////////////////
	// Burst FSM
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			state    <= RD_IDLE;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
			req_cnt  <= '0;
		end
		else if (!i_cfg_en)
		begin
			state    <= RD_IDLE;
			o_wb_cyc <= 1'b0;
			o_wb_stb <= 1'b0;
			req_cnt  <= '0;
		end
		else
		begin
			case (state)
			RD_IDLE:
				// Start only with room for a full burst
				if (i_fill < fill_t'(BURST_LEN))
				begin
					state    <= RD_REQ;
					o_wb_cyc <= 1'b1;
					o_wb_stb <= 1'b1;
					req_cnt  <= '0;
				end
			RD_REQ:
				if (accept)
				begin
					req_cnt <= req_cnt + 1'b1;
					if (last_req)
					begin
						o_wb_stb <= 1'b0;
						state    <= RD_DRAIN;
					end
				end
			RD_DRAIN:
				// Final ack closes the cycle
				if (i_wb_ack && outstanding == cnt_t'(1))
				begin
					o_wb_cyc <= 1'b0;
					state    <= RD_IDLE;
				end
			default:
				state <= RD_IDLE;
			endcase
		end
	end

	// Requests in flight
	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
			outstanding <= '0;
		else if (!i_cfg_en)
			outstanding <= '0;
		else if (accept && !o_push)
			outstanding <= outstanding + 1'b1;
		else if (!accept && o_push)
			outstanding <= outstanding - 1'b1;
	end

	//////////////////////////////
	// Address generation
	//////////////////////////////

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			req_col   <= '0;
			req_row   <= '0;
			o_wb_addr <= '0;
			row_addr  <= '0;
		end
		else if (!i_cfg_en)
		begin
			// Park at the frame base
			req_col   <= '0;
			req_row   <= '0;
			o_wb_addr <= i_cfg.base;
			row_addr  <= i_cfg.base + addr_t'(i_cfg.mem_words);
		end
		else if (accept)
		begin
			if (req_col == i_cfg.mem_words - dim_t'(1))
			begin
				req_col <= '0;
				if (req_row == i_cfg.height - dim_t'(1))
				begin
					// Frame done, wrap
					req_row   <= '0;
					o_wb_addr <= i_cfg.base;
					row_addr  <= i_cfg.base + addr_t'(i_cfg.mem_words);
				end
				else
				begin
					req_row   <= req_row + 1'b1;
					o_wb_addr <= row_addr;
					row_addr  <= row_addr + addr_t'(i_cfg.mem_words);
				end
			end
			else
			begin
				req_col   <= req_col + 1'b1;
				o_wb_addr <= o_wb_addr + 1'b1;
			end
		end
	end

	//////////////////////////////
	// Ack tagging
	//////////////////////////////

	assign ack_hlast = (ack_col == i_cfg.mem_words - dim_t'(1));

	always_ff @(posedge i_clk or posedge i_reset)
	begin
		if (i_reset)
		begin
			ack_col <= '0;
			ack_row <= '0;
		end
		else if (!i_cfg_en)
		begin
			ack_col <= '0;
			ack_row <= '0;
		end
		else if (state == RD_IDLE)
		begin
			// Nothing in flight, so both sides agree
			ack_col <= req_col;
			ack_row <= req_row;
		end
		else if (o_push)
		begin
			if (ack_hlast)
			begin
				ack_col <= '0;
				if (ack_row == i_cfg.height - dim_t'(1))
					ack_row <= '0;
				else
					ack_row <= ack_row + 1'b1;
			end
			else
				ack_col <= ack_col + 1'b1;
		end
	end

	always_comb
	begin
		o_push_word.data  = i_wb_data;
		o_push_word.hlast = ack_hlast;
		o_push_word.vlast = (ack_row == i_cfg.height - dim_t'(1));
	end

	// Bus protocol checks
	a_stb_cyc: assert property (@(posedge i_clk) disable iff (i_reset)
		o_wb_stb |-> o_wb_cyc);
	a_max_out: assert property (@(posedge i_clk) disable iff (i_reset)
		outstanding <= cnt_t'(BURST_LEN));
	a_no_stray: assert property (@(posedge i_clk) disable iff (i_reset)
		!o_wb_cyc |-> !i_wb_ack);

endmodule

/* tb/tb_vid_framebuf.sv */
// Random bus stall, ack delay and stream ready from a fixed LFSR seed
// Checks addresses and two full frames of a 5 x 6 word image
`timescale 1ns/1ps
module tb_vid_framebuf import fb_pkg::*; ();

	//////////////////////////////
	// Test geometry
	//////////////////////////////

	localparam addr_t BASE          = 20'h100;
	localparam int    ROW_WORDS     = 5;
	localparam int    ROWS          = 6;
	localparam int    PIX_PER_ROW   = ROW_WORDS * PIX_PER_WORD;
	localparam int    PIX_PER_FRAME = PIX_PER_ROW * ROWS;
	localparam int    TOTAL_PIX     = 2 * PIX_PER_FRAME;
	// 240 pixels at about half rate plus bus latency and wide margin
	localparam int    CYCLE_LIMIT   = 6000;
	localparam addr_t DATA_KEY      = 20'hA5C3E;

	logic      i_clk;
	logic      i_reset;
	logic      i_cfg_en;
	vid_cfg_t  i_cfg;
	logic      o_wb_cyc;
	logic      o_wb_stb;
	addr_t     o_wb_addr;
	logic      i_wb_stall;
	logic      i_wb_ack;
	word_t     i_wb_data;
	logic      o_vid_valid;
	vid_beat_t o_vid_beat;
	logic      i_vid_ready;

	// Model state
	logic [16:0] lfsr = 17'd78857;
	addr_t       req_q[$];
	int          exp_row = 0;
	int          exp_col = 0;
	int          accepted_cnt = 0;
	int          acked_cnt = 0;
	int          pix_count = 0;
	int          cycles = 0;
	logic        watch_hold = 1'b0;
	vid_beat_t   held_beat;
	vid_beat_t   exp_beat;

	vid_framebuf vid_framebuf_i (
		.i_clk       (i_clk),
		.i_reset     (i_reset),
		.i_cfg_en    (i_cfg_en),
		.i_cfg       (i_cfg),
		.o_wb_cyc    (o_wb_cyc),
		.o_wb_stb    (o_wb_stb),
		.o_wb_addr   (o_wb_addr),
		.i_wb_stall  (i_wb_stall),
		.i_wb_ack    (i_wb_ack),
		.i_wb_data   (i_wb_data),
		.o_vid_valid (o_vid_valid),
		.o_vid_beat  (o_vid_beat),
		.i_vid_ready (i_vid_ready)
	);

	//////////////////////////////
	// Helpers
	//////////////////////////////

	// 17 bit Fibonacci LFSR with taps 17 and 14
	// One step per returned bit
	function automatic logic [15:0] rand_bits(input int n);
		logic [15:0] r;
		logic        fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb   = lfsr[16] ^ lfsr[13];
			lfsr = {lfsr[15:0], fb};
			r    = {r[14:0], fb};
		end
		return r;
	endfunction

	// Memory word is the keyed address spread over all 32 bits
	function automatic word_t word_of(input addr_t a);
		addr_t x;
		x = a ^ DATA_KEY;
		return {x, x[19:8]};
	endfunction

	// Expected beat n of the repeating frame stream
	function automatic vid_beat_t expected_beat(input int n);
		int        idx;
		int        row;
		int        col;
		int        b;
		word_t     w;
		vid_beat_t e;
		idx    = n % PIX_PER_FRAME;
		row    = idx / PIX_PER_ROW;
		col    = (idx % PIX_PER_ROW) / PIX_PER_WORD;
		b      = idx % PIX_PER_WORD;
		w      = word_of(BASE + addr_t'(row * ROW_WORDS + col));
		// Byte 0 is the most significant
		e.data = pix_t'(w >> (PIX_W * (PIX_PER_WORD - 1 - b)));
		e.last = ((idx % PIX_PER_ROW) == PIX_PER_ROW - 1);
		e.user = (idx == 0);
		return e;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("TEST FAIL");
		$fatal(1);
	endtask

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected)
			stop_on_error($sformatf("mismatch %s: actual 0x%h expected 0x%h",
				name, actual, expected));
	endtask

	//////////////////////////////
	// Clock and sequence
	//////////////////////////////

	initial
	begin
		i_clk = 1'b0;
		forever #5 i_clk = ~i_clk;
	end

	initial
	begin
		i_reset         = 1'b1;
		i_cfg_en        = 1'b0;
		i_cfg.base      = BASE;
		i_cfg.mem_words = dim_t'(ROW_WORDS);
		i_cfg.height    = dim_t'(ROWS);
		i_wb_stall      = 1'b0;
		i_wb_ack        = 1'b0;
		i_wb_data       = '0;
		i_vid_ready     = 1'b0;
		repeat (10) @(posedge i_clk);
		i_reset <= 1'b0;
		// Quiet outputs until enabled
		repeat (4)
		begin
			@(posedge i_clk);
			check_value("o_wb_cyc", 32'(o_wb_cyc), 32'd0);
			check_value("o_wb_stb", 32'(o_wb_stb), 32'd0);
			check_value("o_vid_valid", 32'(o_vid_valid), 32'd0);
		end
		i_cfg_en <= 1'b1;
		// Counters settle by the falling edge
		while (pix_count < TOTAL_PIX && cycles < CYCLE_LIMIT)
			@(negedge i_clk);
		if (pix_count >= TOTAL_PIX)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
			stop_on_error($sformatf("timeout after %0d cycles with %0d of %0d pixels",
				cycles, pix_count, TOTAL_PIX));
	end

	//////////////////////////////
	// Bus model and stream checks
	//////////////////////////////

	always @(posedge i_clk)
	begin
		if (!i_reset)
		begin
			cycles = cycles + 1;

			// Accepted request address follows row order
			if (o_wb_stb && !i_wb_stall)
			begin
				check_value("o_wb_addr", 32'(o_wb_addr),
					32'(BASE + addr_t'(exp_row * ROW_WORDS + exp_col)));
				req_q.push_back(o_wb_addr);
				accepted_cnt++;
				if (exp_col == ROW_WORDS - 1)
				begin
					exp_col = 0;
					exp_row = (exp_row == ROWS - 1) ? 0 : exp_row + 1;
				end
				else
					exp_col++;
			end
			if (i_wb_ack)
			begin
				void'(req_q.pop_front());
				acked_cnt++;
			end

			// Held beat from the last edge must be unchanged
			if (watch_hold)
			begin
				check_value("o_vid_valid", 32'(o_vid_valid), 32'd1);
				check_value("o_vid_beat", 32'(o_vid_beat), 32'(held_beat));
			end
			watch_hold = o_vid_valid && !i_vid_ready;
			held_beat  = o_vid_beat;

			if (o_vid_valid && i_vid_ready)
			begin
				exp_beat = expected_beat(pix_count);
				check_value("o_vid_beat.data", 32'(o_vid_beat.data), 32'(exp_beat.data));
				check_value("o_vid_beat.last", 32'(o_vid_beat.last), 32'(exp_beat.last));
				check_value("o_vid_beat.user", 32'(o_vid_beat.user), 32'(exp_beat.user));
				pix_count++;
			end

			// In flight plus buffered words fit the FIFO and unpacker
			if (accepted_cnt - acked_cnt > BURST_LEN)
				stop_on_error("more than 16 read requests in flight");
			if ((accepted_cnt - acked_cnt) + (acked_cnt - pix_count / PIX_PER_WORD)
				> FIFO_DEPTH)
				stop_on_error("requests in flight exceed the free FIFO space");

			// Next cycle stimulus
			i_wb_stall  <= (rand_bits(2) == 0);
			i_vid_ready <= (rand_bits(4) < 10);
			if (req_q.size() > 0 && rand_bits(1) == 1)
			begin
				i_wb_ack  <= 1'b1;
				i_wb_data <= word_of(req_q[0]);
			end
			else
				i_wb_ack <= 1'b0;
		end
	end

endmodule

/* vid_framebuf.f */
logic/fb_pkg.sv
logic/wb_burst_reader.sv
logic/px_fifo.sv
logic/px_unpacker.sv
logic/vid_framebuf.sv
tb/tb_vid_framebuf.sv
